//--- rtl/uart_pkg.sv
// UART definitions
// Serial bit timing and the character type shared by receiver and transmitter

package uart_pkg;

  // Bit timing ---------------------------------------------------------
  localparam int BAUD_DIV   = 16;  // clocks per serial bit
  localparam int FRAME_BITS = 10;  // start + 8 data + stop

  // Types --------------------------------------------------------------
  typedef logic [7:0] byte_t;                          // one serial character
  typedef logic [$clog2(BAUD_DIV)-1:0] baud_cnt_t;     // clock count inside a bit
  typedef logic [$clog2(FRAME_BITS)-1:0] bit_cnt_t;    // bit position in a frame

endpackage

//--- rtl/cmd_pkg.sv
// Command bridge definitions
// Line format, ASCII codes, reply kinds, FSM states, AHB codes, hex helpers

package cmd_pkg;

  typedef logic [31:0] word_t;      // address and data
  typedef logic [4:0]  len_t;       // line byte count
  typedef logic [15:0] err_code_t;  // two ASCII digits
  typedef logic [4:0]  ridx_t;      // reply byte index

  // Line format
  localparam len_t MAX_LINE    = 5'd25;  // count saturates here
  localparam len_t WR_BODY_LEN = 5'd23;  // "W 0xAAAAAAAA 0xDDDDDDDD"
  localparam len_t RD_BODY_LEN = 5'd12;  // "R 0xAAAAAAAA"

  // ASCII codes
  localparam uart_pkg::byte_t ASCII_SPACE = 8'h20;
  localparam uart_pkg::byte_t ASCII_CR    = 8'h0D;
  localparam uart_pkg::byte_t ASCII_LF    = 8'h0A;
  localparam uart_pkg::byte_t ASCII_COLON = 8'h3A;
  localparam uart_pkg::byte_t ASCII_EQUAL = 8'h3D;
  localparam uart_pkg::byte_t ASCII_0     = 8'h30;
  localparam uart_pkg::byte_t ASCII_1     = 8'h31;
  localparam uart_pkg::byte_t ASCII_2     = 8'h32;
  localparam uart_pkg::byte_t ASCII_3     = 8'h33;
  localparam uart_pkg::byte_t ASCII_4     = 8'h34;
  localparam uart_pkg::byte_t ASCII_9     = 8'h39;
  localparam uart_pkg::byte_t ASCII_A     = 8'h41;
  localparam uart_pkg::byte_t ASCII_F     = 8'h46;
  localparam uart_pkg::byte_t ASCII_R     = 8'h52;
  localparam uart_pkg::byte_t ASCII_W     = 8'h57;
  localparam uart_pkg::byte_t ASCII_X     = 8'h58;
  localparam uart_pkg::byte_t ASCII_a     = 8'h61;
  localparam uart_pkg::byte_t ASCII_f     = 8'h66;
  localparam uart_pkg::byte_t ASCII_r     = 8'h72;
  localparam uart_pkg::byte_t ASCII_w     = 8'h77;
  localparam uart_pkg::byte_t ASCII_x     = 8'h78;

  // Replies ------------------------------------------------------------
  typedef enum logic [1:0] {REPLY_RDATA, REPLY_AHBERR, REPLY_DECERR} reply_kind_t;

  localparam ridx_t RDATA_LEN  = 5'd20;  // text + 8 hex + CR LF
  localparam ridx_t AHBERR_LEN = 5'd29;  // text + 8 hex + CR LF
  localparam ridx_t DECERR_LEN = 5'd18;  // text + code + CR LF

  // Fixed leading text of each reply
  localparam int RDATA_PRE  = 10;
  localparam int AHBERR_PRE = 19;
  localparam int DECERR_PRE = 14;
  localparam logic [8*RDATA_PRE-1:0]  RDATA_TXT  = {"HRDATA", ASCII_COLON, " 0x"};
  localparam logic [8*AHBERR_PRE-1:0] AHBERR_TXT =
    {"AHB_ERROR", ASCII_COLON, " HADDR", ASCII_EQUAL, "0x"};
  localparam logic [8*DECERR_PRE-1:0] DECERR_TXT = {"DECODE_ERROR", ASCII_COLON, ASCII_SPACE};

  // Transaction FSM
  typedef enum logic [2:0] {
    ST_IDLE, ST_ADDR, ST_WDATA, ST_RDATA, ST_REPLY, ST_DONE
  } state_t;

  // AHB-Lite codes
  localparam logic [1:0] AHB_IDLE   = 2'b00;
  localparam logic [1:0] AHB_NONSEQ = 2'b10;
  localparam logic [2:0] AHB_WORD   = 3'b010;

  // Hex conversion -----------------------------------------------------
  function automatic logic hex_is_bad(input uart_pkg::byte_t c);
    return !(((c >= ASCII_0) && (c <= ASCII_9)) ||
             ((c >= ASCII_A) && (c <= ASCII_F)) ||
             ((c >= ASCII_a) && (c <= ASCII_f)));
  endfunction

  function automatic logic [3:0] hex_to_nibble(input uart_pkg::byte_t c);
    if (c <= ASCII_9) return 4'(c - ASCII_0);
    if (c >= ASCII_a) return 4'(c - ASCII_a + 8'd10);
    return 4'(c - ASCII_A + 8'd10);
  endfunction

  function automatic uart_pkg::byte_t nibble_to_hex(input logic [3:0] n);
    return (n < 4'd10) ? uart_pkg::byte_t'(ASCII_0 + n) : uart_pkg::byte_t'(ASCII_A + n - 8'd10);
  endfunction

endpackage

//--- rtl/uart_rx.sv
// UART receiver
// 8N1, start bit edge detect, mid-bit sampling, stop bit check

`timescale 1ns/10ps

module uart_rx (
  input  logic            clk,
  input  logic            rstn,
  input  logic            rxd,       // serial input, async to clk
  output logic            rx_valid,  // one pulse per good byte
  output uart_pkg::byte_t rx_byte
);

  logic rxd_m, rxd_s;             // two-flop synchronizer
  logic busy;                     // frame in progress
  uart_pkg::baud_cnt_t baud_cnt;
  uart_pkg::bit_cnt_t  bit_cnt;   // 0 start, 1..8 data, 9 stop
  uart_pkg::byte_t     shreg;
  logic mid;

  assign mid     = busy && (baud_cnt == uart_pkg::baud_cnt_t'(uart_pkg::BAUD_DIV/2 - 1));
  assign rx_byte = shreg;  // stable until next frame shifts in

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rxd_m    <= 1'b1;
      rxd_s    <= 1'b1;
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rxd_m    <= rxd;
      rxd_s    <= rxd_m;
      rx_valid <= 1'b0;
      if (!busy) begin
        if (!rxd_s) begin  // Falling edge, start bit
          busy     <= 1'b1;
          baud_cnt <= '0;
          bit_cnt  <= '0;
        end
      end else begin
        baud_cnt <= (baud_cnt == uart_pkg::baud_cnt_t'(uart_pkg::BAUD_DIV - 1)) ?
                    '0 : baud_cnt + 1'b1;
        if (mid) begin
          bit_cnt <= bit_cnt + 1'b1;
          if ((bit_cnt == '0) && rxd_s) begin
            busy <= 1'b0;  // Glitch, not a start bit
          end else if (bit_cnt == uart_pkg::bit_cnt_t'(uart_pkg::FRAME_BITS - 1)) begin
            busy     <= 1'b0;
            rx_valid <= rxd_s;  // Low stop bit drops the byte
          end
        end
      end
    end
  end

  // LSB first
  always_ff @(posedge clk) begin
    if (mid && (bit_cnt != '0) && (bit_cnt != uart_pkg::bit_cnt_t'(uart_pkg::FRAME_BITS - 1)))
      shreg <= {rxd_s, shreg[7:1]};
  end

endmodule

//--- rtl/uart_tx.sv
// UART transmitter
// 8N1 frame out of a shift register, busy until the end of the stop bit

`timescale 1ns/10ps

module uart_tx (
  input  logic            clk,
  input  logic            rstn,
  input  logic            tx_start,  // latch tx_byte, ignored while busy
  input  uart_pkg::byte_t tx_byte,
  output logic            txd,
  output logic            tx_busy
);

  logic [uart_pkg::FRAME_BITS-1:0] frame;  // stop, data, start; bit 0 on the line
  uart_pkg::baud_cnt_t baud_cnt;
  uart_pkg::bit_cnt_t  bit_cnt;

  assign txd = frame[0];

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      frame    <= '1;  // Line idles high
      tx_busy  <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else if (!tx_busy) begin
      if (tx_start) begin
        frame    <= {1'b1, tx_byte, 1'b0};
        tx_busy  <= 1'b1;
        baud_cnt <= '0;
        bit_cnt  <= '0;
      end
    end else if (baud_cnt == uart_pkg::baud_cnt_t'(uart_pkg::BAUD_DIV - 1)) begin
      baud_cnt <= '0;
      frame    <= {1'b1, frame[uart_pkg::FRAME_BITS-1:1]};  // Next bit, fill idle
      if (bit_cnt == uart_pkg::bit_cnt_t'(uart_pkg::FRAME_BITS - 1))
        tx_busy <= 1'b0;  // Stop bit done
      else
        bit_cnt <= bit_cnt + 1'b1;
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

endmodule

//--- rtl/cmd_parser.sv
// Command line parser
// Buffers one line, then decodes address, data and the error code

`timescale 1ns/10ps

module cmd_parser (
  input  logic                clk,
  input  logic                rstn,
  input  logic                rx_valid,
  input  uart_pkg::byte_t     rx_byte,
  output logic                cmd_valid,
  output logic                cmd_write,
  output cmd_pkg::word_t      cmd_addr,
  output cmd_pkg::word_t      cmd_wdata,
  output logic                cmd_bad,
  output cmd_pkg::err_code_t  err_code
);

  uart_pkg::byte_t line_buf [cmd_pkg::MAX_LINE];  // filled by index
  uart_pkg::byte_t line_q   [cmd_pkg::MAX_LINE];  // snapshot for decode
  cmd_pkg::len_t   cnt, body_len;
  logic            rx_lf, has_cr, eol;
  logic            is_wr, is_rd, bad;
  cmd_pkg::word_t  addr_d, data_d;
  cmd_pkg::err_code_t code;

  // " 0x" or " 0X"
  function automatic logic sep_ok(input uart_pkg::byte_t a, input uart_pkg::byte_t b,
                                  input uart_pkg::byte_t c);
    return (a == cmd_pkg::ASCII_SPACE) && (b == cmd_pkg::ASCII_0) &&
           ((c == cmd_pkg::ASCII_x) || (c == cmd_pkg::ASCII_X));
  endfunction

  assign rx_lf  = rx_valid && (rx_byte == cmd_pkg::ASCII_LF);
  assign has_cr = (cnt != '0) && (line_buf[cnt - 1'b1] == cmd_pkg::ASCII_CR);

  //--------------------------------------------------------------------
  // Line capture
  //--------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cnt       <= '0;
      eol       <= 1'b0;
      cmd_valid <= 1'b0;
    end else begin
      eol       <= rx_lf;  // Decode cycle
      cmd_valid <= eol;    // Results out two cycles after LF
      if (rx_lf)
        cnt <= '0;
      else if (rx_valid && (cnt != cmd_pkg::MAX_LINE))
        cnt <= cnt + 1'b1;  // Saturates
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid && !rx_lf && (cnt != cmd_pkg::MAX_LINE))
      line_buf[cnt] <= rx_byte;
    if (rx_lf) begin
      line_q   <= line_buf;
      body_len <= has_cr ? cnt - 1'b1 : cnt;  // Drop trailing CR
    end
    if (eol) begin
      cmd_write <= is_wr;
      cmd_addr  <= addr_d;
      cmd_wdata <= data_d;
      cmd_bad   <= bad;
      err_code  <= code;
    end
  end

  //--------------------------------------------------------------------
  // Decode, lowest priority check first so later ones win
  //--------------------------------------------------------------------
  always_comb begin
    is_wr = (line_q[0] == cmd_pkg::ASCII_W) || (line_q[0] == cmd_pkg::ASCII_w);
    is_rd = (line_q[0] == cmd_pkg::ASCII_R) || (line_q[0] == cmd_pkg::ASCII_r);
    for (int k = 0; k < 8; k++) begin
      addr_d[4*k +: 4] = cmd_pkg::hex_to_nibble(line_q[11-k]);  // digit 0 is rightmost
      data_d[4*k +: 4] = cmd_pkg::hex_to_nibble(line_q[22-k]);
    end
    code = '0;
    if (is_wr) begin
      for (int k = 7; k >= 0; k--)
        if (cmd_pkg::hex_is_bad(line_q[22-k]))
          code = {uart_pkg::byte_t'(cmd_pkg::ASCII_0 + k), cmd_pkg::ASCII_4};
    end
    for (int k = 7; k >= 0; k--)
      if (cmd_pkg::hex_is_bad(line_q[11-k]))
        code = {uart_pkg::byte_t'(cmd_pkg::ASCII_0 + k), cmd_pkg::ASCII_3};
    if (is_wr && !sep_ok(line_q[12], line_q[13], line_q[14]))
      code = {cmd_pkg::ASCII_1, cmd_pkg::ASCII_2};
    if (!sep_ok(line_q[1], line_q[2], line_q[3]))
      code = {cmd_pkg::ASCII_0, cmd_pkg::ASCII_2};
    if (body_len != (is_wr ? cmd_pkg::WR_BODY_LEN : cmd_pkg::RD_BODY_LEN))
      code = {cmd_pkg::ASCII_0, cmd_pkg::ASCII_1};
    if (!is_wr && !is_rd)
      code = {cmd_pkg::ASCII_1, cmd_pkg::ASCII_1};  // Unknown letter
    bad = (code != '0);
  end

endmodule

//--- rtl/cmd_fsm.sv
// Transaction FSM
// Runs one AHB-Lite word transfer per command and starts the reply

`timescale 1ns/10ps

module cmd_fsm (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 cmd_valid,
  input  logic                 cmd_write,
  input  cmd_pkg::word_t       cmd_addr,
  input  cmd_pkg::word_t       cmd_wdata,
  input  logic                 cmd_bad,
  input  logic                 hready,
  input  logic                 hresp,
  input  cmd_pkg::word_t       hrdata,
  input  logic                 reply_done,
  output cmd_pkg::word_t       haddr,
  output logic [1:0]           htrans,
  output logic [2:0]           hsize,
  output logic                 hwrite,
  output cmd_pkg::word_t       hwdata,
  output logic                 reply_start,   // one cycle on entering ST_REPLY
  output cmd_pkg::reply_kind_t reply_kind,
  output cmd_pkg::word_t       rdata
);

  cmd_pkg::state_t state;
  logic addr_ph, data_end;

  assign addr_ph  = (state == cmd_pkg::ST_ADDR);
  assign data_end = (state == cmd_pkg::ST_WDATA) || (state == cmd_pkg::ST_RDATA);

  // Address phase only, bus idle otherwise
  assign haddr  = addr_ph ? cmd_addr : '0;
  assign hwrite = addr_ph && cmd_write;
  assign htrans = addr_ph ? cmd_pkg::AHB_NONSEQ : cmd_pkg::AHB_IDLE;
  assign hsize  = addr_ph ? cmd_pkg::AHB_WORD : 3'b000;
  assign hwdata = (state == cmd_pkg::ST_WDATA) ? cmd_wdata : '0;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state       <= cmd_pkg::ST_IDLE;
      reply_start <= 1'b0;
      reply_kind  <= cmd_pkg::REPLY_RDATA;
    end else begin
      reply_start <= 1'b0;
      case (state)
        cmd_pkg::ST_IDLE: if (cmd_valid) begin  // Lines seen elsewhere are dropped
          if (cmd_bad) begin
            state       <= cmd_pkg::ST_REPLY;
            reply_kind  <= cmd_pkg::REPLY_DECERR;
            reply_start <= 1'b1;
          end else begin
            state <= cmd_pkg::ST_ADDR;
          end
        end
        cmd_pkg::ST_ADDR: state <= cmd_write ? cmd_pkg::ST_WDATA : cmd_pkg::ST_RDATA;
        cmd_pkg::ST_WDATA, cmd_pkg::ST_RDATA: if (hresp) begin
          state       <= cmd_pkg::ST_REPLY;  // Error response, report address
          reply_kind  <= cmd_pkg::REPLY_AHBERR;
          reply_start <= 1'b1;
        end else if (hready) begin  // Wait states hold here
          if (state == cmd_pkg::ST_WDATA) begin
            state <= cmd_pkg::ST_DONE;  // Silent write
          end else begin
            state       <= cmd_pkg::ST_REPLY;
            reply_kind  <= cmd_pkg::REPLY_RDATA;
            reply_start <= 1'b1;
          end
        end
        cmd_pkg::ST_REPLY: if (reply_done) state <= cmd_pkg::ST_DONE;
        default: state <= cmd_pkg::ST_IDLE;  // ST_DONE, one cycle
      endcase
    end
  end

  // Read data for the reply
  always_ff @(posedge clk) begin
    if (data_end && !cmd_write && hready && !hresp)
      rdata <= hrdata;
  end

endmodule

//--- rtl/reply_counter.sv
// Reply byte counter
// Paces reply bytes into the transmitter and flags the last one

`timescale 1ns/10ps

module reply_counter (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 reply_start,
  input  cmd_pkg::reply_kind_t reply_kind,
  input  logic                 tx_busy,
  output cmd_pkg::ridx_t       ridx,
  output logic                 tx_start,
  output logic                 reply_done
);

  logic active;
  logic gap;  // tx_busy not yet up after a start
  logic last;
  cmd_pkg::ridx_t len;

  always_comb begin
    case (reply_kind)
      cmd_pkg::REPLY_AHBERR: len = cmd_pkg::AHBERR_LEN;
      cmd_pkg::REPLY_DECERR: len = cmd_pkg::DECERR_LEN;
      default:               len = cmd_pkg::RDATA_LEN;
    endcase
  end

  assign tx_start = active && !tx_busy && !gap;
  assign last     = (ridx == len - 1'b1);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      active     <= 1'b0;
      gap        <= 1'b0;
      ridx       <= '0;
      reply_done <= 1'b0;
    end else begin
      gap        <= tx_start;
      reply_done <= tx_start && last;
      if (reply_start) begin
        active <= 1'b1;
        ridx   <= '0;
      end else if (tx_start) begin
        ridx <= ridx + 1'b1;
        if (last) active <= 1'b0;  // Final byte handed over
      end
    end
  end

endmodule

//--- rtl/reply_formatter.sv
// Reply formatter
// Picks the reply character for a kind and byte index

`timescale 1ns/10ps

module reply_formatter (
  input  cmd_pkg::reply_kind_t reply_kind,
  input  cmd_pkg::ridx_t       ridx,
  input  cmd_pkg::word_t       rdata,
  input  cmd_pkg::word_t       cmd_addr,
  input  cmd_pkg::err_code_t   err_code,
  output uart_pkg::byte_t      tx_byte
);

  int pos;

  // Hex digit k of a word, k=0 most significant
  function automatic uart_pkg::byte_t hex_digit(input cmd_pkg::word_t w, input int k);
    return cmd_pkg::nibble_to_hex(w[4*(7-k) +: 4]);
  endfunction

  always_comb begin
    pos     = int'(ridx);
    tx_byte = cmd_pkg::ASCII_LF;  // Last byte of every reply
    case (reply_kind)
      cmd_pkg::REPLY_RDATA: begin
        if (pos < cmd_pkg::RDATA_PRE)
          tx_byte = cmd_pkg::RDATA_TXT[8*(cmd_pkg::RDATA_PRE-1-pos) +: 8];
        else if (pos < cmd_pkg::RDATA_PRE + 8)
          tx_byte = hex_digit(rdata, pos - cmd_pkg::RDATA_PRE);
        else if (pos == cmd_pkg::RDATA_PRE + 8)
          tx_byte = cmd_pkg::ASCII_CR;
      end
      cmd_pkg::REPLY_AHBERR: begin
        if (pos < cmd_pkg::AHBERR_PRE)
          tx_byte = cmd_pkg::AHBERR_TXT[8*(cmd_pkg::AHBERR_PRE-1-pos) +: 8];
        else if (pos < cmd_pkg::AHBERR_PRE + 8)
          tx_byte = hex_digit(cmd_addr, pos - cmd_pkg::AHBERR_PRE);  // Failing address
        else if (pos == cmd_pkg::AHBERR_PRE + 8)
          tx_byte = cmd_pkg::ASCII_CR;
      end
      default: begin  // Decode error
        if (pos < cmd_pkg::DECERR_PRE)
          tx_byte = cmd_pkg::DECERR_TXT[8*(cmd_pkg::DECERR_PRE-1-pos) +: 8];
        else if (pos == cmd_pkg::DECERR_PRE)
          tx_byte = err_code[15:8];
        else if (pos == cmd_pkg::DECERR_PRE + 1)
          tx_byte = err_code[7:0];
        else if (pos == cmd_pkg::DECERR_PRE + 2)
          tx_byte = cmd_pkg::ASCII_CR;
      end
    endcase
  end

endmodule

//--- rtl/uart_ahb_bridge.sv
// UART to AHB-Lite bridge top
// Serial command lines in, one AHB word transfer and an ASCII reply out

`timescale 1ns/10ps

module uart_ahb_bridge (
  input  logic           clk,
  input  logic           rstn,
  input  logic           rxd,
  output logic           txd,
  output cmd_pkg::word_t haddr,
  output logic [1:0]     htrans,
  output logic [2:0]     hsize,
  output logic           hwrite,
  output cmd_pkg::word_t hwdata,
  input  cmd_pkg::word_t hrdata,
  input  logic           hready,
  input  logic           hresp
);

  // Receive path
  logic                 rx_valid;
  uart_pkg::byte_t      rx_byte;
  logic                 cmd_valid, cmd_write, cmd_bad;
  cmd_pkg::word_t       cmd_addr, cmd_wdata;
  cmd_pkg::err_code_t   err_code;
  // Reply path
  logic                 reply_start, reply_done;
  cmd_pkg::reply_kind_t reply_kind;
  cmd_pkg::word_t       rdata;
  cmd_pkg::ridx_t       ridx;
  logic                 tx_start, tx_busy;
  uart_pkg::byte_t      tx_byte;

  uart_rx u_rx (.clk, .rstn, .rxd, .rx_valid, .rx_byte);

  cmd_parser u_parser (
    .clk, .rstn, .rx_valid, .rx_byte,
    .cmd_valid, .cmd_write, .cmd_addr, .cmd_wdata, .cmd_bad, .err_code
  );

  cmd_fsm u_fsm (
    .clk, .rstn, .cmd_valid, .cmd_write, .cmd_addr, .cmd_wdata, .cmd_bad,
    .hready, .hresp, .hrdata, .reply_done,
    .haddr, .htrans, .hsize, .hwrite, .hwdata, .reply_start, .reply_kind, .rdata
  );

  reply_counter u_rcnt (
    .clk, .rstn, .reply_start, .reply_kind, .tx_busy, .ridx, .tx_start, .reply_done
  );

  reply_formatter u_fmt (.reply_kind, .ridx, .rdata, .cmd_addr, .err_code, .tx_byte);

  uart_tx u_tx (.clk, .rstn, .tx_start, .tx_byte, .txd, .tx_busy);

endmodule

//--- verif/tb_uart_ahb_bridge.sv
// Testbench for the UART to AHB-Lite bridge
// Serial driver and monitor, AHB slave memory with wait states, directed tests

`timescale 1ns/10ps

module tb_uart_ahb_bridge;

  // Run length ---------------------------------------------------------
  localparam int BYTE_CYCLES = 10 * uart_pkg::BAUD_DIV;  // one 8N1 frame
  localparam int LINE_BYTES  = 320;  // all command bytes sent
  localparam int REPLY_BYTES = 230;  // all reply bytes expected
  localparam int MAX_CYCLES  = 2 * (LINE_BYTES + REPLY_BYTES) * BYTE_CYCLES;  // x2 margin

  logic        clk = 1'b0;
  logic        rstn, rxd, txd;
  logic [31:0] haddr, hwdata, hrdata;
  logic [1:0]  htrans;
  logic [2:0]  hsize;
  logic        hwrite, hready, hresp;

  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycles = 0;
  integer      seed = 32'he7e;
  logic [7:0]  rx_q[$];           // reply bytes, oldest first
  logic [31:0] mem[64];           // slave memory, word index
  int          nonseq_cnt = 0;    // address phases seen
  int          done_cnt = 0;      // data phases finished
  logic [31:0] last_addr, last_wdata;
  logic        last_write;
  logic [2:0]  last_size;

  uart_ahb_bridge uut (
    .clk, .rstn, .rxd, .txd, .haddr, .htrans, .hsize, .hwrite, .hwdata,
    .hrdata, .hready, .hresp
  );

  always #20 clk = ~clk;  // 40 ns period

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Run stopped after %0d cycles, a test never finished", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // AHB slave ----------------------------------------------------------
  initial begin
    int         dcnt;   // data phase cycles left
    logic       err;
    logic [5:0] idx;
    dcnt   = 0;
    err    = 1'b0;
    idx    = '0;
    hready = 1'b1;
    hresp  = 1'b0;
    hrdata = '0;
    for (int i = 0; i < 64; i++)
      mem[i] = 32'h5A5A_0000 ^ 32'(i * 4);  // whole byte address
    forever begin
      @(posedge clk);
      #1;
      if (dcnt > 0) begin
        dcnt   = dcnt - 1;
        hready = (dcnt == 0);    // low while waiting
        hresp  = (dcnt == 0) && err;
        if (dcnt == 0) begin     // Last data cycle
          done_cnt++;
          hrdata     = err ? '0 : mem[idx];
          last_wdata = hwdata;
          if (last_write && !err)
            mem[idx] = hwdata;
        end
      end else begin
        hready = 1'b1;
        hresp  = 1'b0;
      end
      if (htrans == 2'b10) begin  // NONSEQ address phase
        nonseq_cnt++;
        last_addr  = haddr;
        last_write = hwrite;
        last_size  = hsize;
        idx        = haddr[7:2];
        err        = (haddr[31:24] == 8'hDE);
        dcnt       = 1 + ($random(seed) & 3);  // 0 to 3 wait states
      end
    end
  end

  // Reply monitor, samples txd on the falling edge
  initial begin
    logic [7:0] b;
    forever begin
      @(negedge clk);
      if (txd === 1'b0) begin
        repeat (uart_pkg::BAUD_DIV / 2) @(negedge clk);  // Mid start bit
        for (int i = 0; i < 8; i++) begin
          repeat (uart_pkg::BAUD_DIV) @(negedge clk);
          b[i] = txd;  // LSB first
        end
        repeat (uart_pkg::BAUD_DIV) @(negedge clk);
        if (txd !== 1'b1) begin
          $display("ERROR: reply byte %h came with a low stop bit", b);
          errors++;
        end
        rx_q.push_back(b);
      end
    end
  end

  // Helpers ------------------------------------------------------------
  task automatic hold_bit(input logic v);
    rxd = v;
    repeat (uart_pkg::BAUD_DIV) @(posedge clk);
    #1;
  endtask

  task automatic send_byte(input logic [7:0] c);
    hold_bit(1'b0);
    for (int j = 0; j < 8; j++)
      hold_bit(c[j]);
    hold_bit(1'b1);
  endtask

  task automatic send_line(input string s, input bit with_cr);
    @(posedge clk);
    #1;
    for (int i = 0; i < s.len(); i++)
      send_byte(s[i]);
    if (with_cr)
      send_byte(8'h0D);
    send_byte(8'h0A);
  endtask

  function automatic string upper_hex(input logic [31:0] w);
    string s;
    s = $sformatf("%08h", w);
    return s.toupper();
  endfunction

  task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("FAILED %s: expected %h, actual %h", name, exp, act);
    errors++;
  endtask

  task automatic complain(input string what);
    $display("ERROR: %s", what);
    errors++;
  endtask

  task automatic wait_done(input string name, input int target);
    int waited;
    waited = 0;
    while ((done_cnt < target) && (waited < 2 * BYTE_CYCLES)) begin
      @(posedge clk);
      waited++;
    end
    if (done_cnt < target)
      complain($sformatf("%s: AHB transfer never completed", name));
  endtask

  // Waits for body + CR LF, then compares
  task automatic expect_reply(input string name, input string body);
    int          n, waited;
    string       act;
    logic [15:0] tail;
    n      = body.len() + 2;
    waited = 0;
    act    = "";
    while ((rx_q.size() < n) && (waited < (n + 2) * BYTE_CYCLES)) begin
      @(posedge clk);
      waited++;
    end
    if (rx_q.size() < n) begin
      complain($sformatf("%s: reply \"%s\" missing, got %0d of %0d bytes",
                         name, body, rx_q.size(), n));
    end else begin
      for (int i = 0; i < n - 2; i++)
        act = $sformatf("%s%c", act, rx_q[i]);
      tail = {rx_q[n-2], rx_q[n-1]};
      if ((act != body) || (tail != 16'h0D0A)) begin
        $display("FAILED %s: expected \"%s\" 0d0a, actual \"%s\" %h", name, body, act, tail);
        errors++;
      end
    end
    rx_q.delete();
  endtask

  task automatic finish_test(input string name, input int err0);
    tests_run++;
    if (errors != err0) begin
      tests_failed++;
      $display("test %-12s failed with %0d errors", name, errors - err0);
    end else begin
      $display("test %-12s done", name);
    end
  endtask

  // Tests --------------------------------------------------------------
  task automatic reset_state();
    int err0, n0, d0;
    err0 = errors;
    if (txd !== 1'b1) mismatch("reset_state txd", 32'd1, {31'd0, txd});
    if (htrans !== 2'b00) mismatch("reset_state htrans", 32'd0, {30'd0, htrans});
    n0 = nonseq_cnt;
    d0 = done_cnt;
    send_line("W 0x00000010 0x12345678", 1'b1);
    wait_done("reset_state", d0 + 1);
    repeat (400) @(posedge clk);  // silent write
    if (nonseq_cnt - n0 != 1) mismatch("reset_state transfers", 32'd1, 32'(nonseq_cnt - n0));
    if (last_addr !== 32'h10) mismatch("reset_state haddr", 32'h10, last_addr);
    if (last_write !== 1'b1) mismatch("reset_state hwrite", 32'd1, {31'd0, last_write});
    if (last_size !== 3'b010) mismatch("reset_state hsize", 32'd2, {29'd0, last_size});
    if (last_wdata !== 32'h12345678) mismatch("reset_state hwdata", 32'h12345678, last_wdata);
    if (rx_q.size() != 0)
      complain($sformatf("reset_state: write sent %0d reply bytes", rx_q.size()));
    rx_q.delete();
    finish_test("reset_state", err0);
  endtask

  task automatic read_back();
    int err0;
    err0 = errors;
    send_line("r 0x00000010", 1'b0);  // LF only
    expect_reply("read_back", "HRDATA: 0x12345678");
    finish_test("read_back", err0);
  endtask

  task automatic decode_case(input string line, input string code);
    int n0;
    n0 = nonseq_cnt;
    send_line(line, 1'b1);
    expect_reply({"decode ", code}, {"DECODE_ERROR: ", code});
    if (nonseq_cnt != n0)
      complain($sformatf("decode %s: line \"%s\" started an AHB transfer", code, line));
  endtask

  task automatic decode_errors();
    int err0;
    err0 = errors;
    decode_case("Q 0x00000010", "11");             // unknown letter
    decode_case("W 0x00000010", "01");             // write too short
    decode_case("R 0x0000G010", "33");             // address digit 3
    decode_case("W 0x00000010 0x1234567Z", "04");  // data digit 0
    finish_test("decode_errors", err0);
  endtask

  task automatic bus_error();
    int err0, d0;
    err0 = errors;
    d0   = done_cnt;
    send_line("R 0xDE000004", 1'b1);
    expect_reply("bus_error", "AHB_ERROR: HADDR=0xDE000004");
    if (done_cnt != d0 + 1) mismatch("bus_error transfers", 32'd1, 32'(done_cnt - d0));
    finish_test("bus_error", err0);
  endtask

  task automatic wait_states();
    int          err0, d0;
    logic [31:0] r, addr, data;
    string       wr, rd;
    err0 = errors;
    for (int i = 0; i < 5; i++) begin
      r    = $random(seed);
      addr = {24'd0, r[5:0], 2'b00};  // one of the 64 words
      data = $random(seed);
      if ((i % 2) == 0) begin
        wr = $sformatf("w 0x%08h 0X%08h", addr, data);  // lower-case digits
        rd = $sformatf("R 0X%08h", addr);
      end else begin
        wr = {"W 0X", upper_hex(addr), " 0x", upper_hex(data)};
        rd = $sformatf("r 0x%08h", addr);
      end
      d0 = done_cnt;
      send_line(wr, (i % 2) == 1);  // CR LF and bare LF
      wait_done($sformatf("wait_states %0d", i), d0 + 1);
      send_line(rd, 1'b1);
      expect_reply($sformatf("wait_states %0d", i), {"HRDATA: 0x", upper_hex(data)});
    end
    finish_test("wait_states", err0);
  endtask

  // Main sequence
  initial begin
    rstn = 1'b0;
    rxd  = 1'b1;  // line idle
    repeat (10) @(posedge clk);
    #1;
    rstn = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    reset_state();
    read_back();
    decode_errors();
    bus_error();
    wait_states();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- build.f
rtl/uart_pkg.sv
rtl/cmd_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/cmd_parser.sv
rtl/cmd_fsm.sv
rtl/reply_counter.sv
rtl/reply_formatter.sv
rtl/uart_ahb_bridge.sv
verif/tb_uart_ahb_bridge.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the UART to AHB bridge testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_uart_ahb_bridge -f build.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
  exit 1
fi
exit 0
